/* common/cvif_pkg.sv */
// Shared definitions for the CVIF configuration and read arbitration blocks.
// Holds CSB packet layouts, register offsets and reset values.
package cvif_pkg;

  // ==================================================
  // CSB packet layout
  // ==================================================
  localparam int unsigned CSB_REQ_W  = 63;  // request packet width
  localparam int unsigned CSB_RESP_W = 34;  // response packet width

  localparam int unsigned REQ_ADDR_LSB    = 0;   // word address
  localparam int unsigned REQ_ADDR_MSB    = 21;
  localparam int unsigned REQ_WDAT_LSB    = 22;  // write data
  localparam int unsigned REQ_WDAT_MSB    = 53;
  localparam int unsigned REQ_WRITE_BIT   = 54;  // 1 = write
  localparam int unsigned REQ_NPOSTED_BIT = 55;  // 1 = write wants a response
  // bits 56..62 carry byte enables, privilege and level, not used here

  localparam int unsigned RESP_KIND_BIT = 33;
  localparam int unsigned RESP_ERR_BIT  = 32;
  localparam int unsigned RESP_DATA_W   = 32;

  // response kind, sits in bit 33 of the response
  typedef enum logic [0:0] {
    RESP_READ  = 1'b0,
    RESP_WRITE = 1'b1
  } csb_resp_kind_e;

  // ==================================================
  // register map
  // ==================================================
  localparam int unsigned WEIGHT_W = 8;  // weight and outstanding count width

  // byte offsets, word address shifted left by 2
  typedef enum logic [11:0] {
    REG_RD_WEIGHT = 12'h000,  // client 0 in low byte
    REG_WR_WEIGHT = 12'h004,
    REG_OS_CNT    = 12'h008,  // rd limit [7:0], wr limit [15:8]
    REG_STATUS    = 12'h00c   // idle in bit 0, read only
  } cvif_reg_e;

  localparam logic [WEIGHT_W-1:0] RST_WEIGHT = 8'h01;
  localparam logic [WEIGHT_W-1:0] RST_OS_CNT = 8'hff;

endpackage

/* cvif/cvif_csb.sv */
// CSB slave for CVIF. Registers each request, drives one register access
// per request and returns a response for reads and non-posted writes.
`timescale 1ns/1ps

module cvif_csb (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          csb2cvif_req_pvld,
  output logic                          csb2cvif_req_prdy,
  input  logic [cvif_pkg::CSB_REQ_W-1:0]  csb2cvif_req_pd,
  output logic                          cvif2csb_resp_valid,
  output logic [cvif_pkg::CSB_RESP_W-1:0] cvif2csb_resp_pd,
  output logic [11:0]                   reg_offset,
  output logic                          reg_wr_en,
  output logic [31:0]                   reg_wr_data,
  input  logic [31:0]                   reg_rd_data
);
  import cvif_pkg::*;

  logic                               req_vld;
  logic [CSB_REQ_W-1:0]               req_pd;
  logic [REQ_ADDR_MSB-REQ_ADDR_LSB:0] req_addr;
  logic [REQ_WDAT_MSB-REQ_WDAT_LSB:0] req_wdat;
  logic                               req_write;
  logic                               req_nposted;
  logic                               rsp_rd_vld;
  logic                               rsp_wr_vld;
  logic                               rsp_vld;
  csb_resp_kind_e                     rsp_kind;
  logic [RESP_DATA_W-1:0]             rsp_data;
  logic [CSB_RESP_W-1:0]              rsp_pd;

  // ==================================================
  // request capture
  // ==================================================
  assign csb2cvif_req_prdy = 1'b1;  // never stalls the bus

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= csb2cvif_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2cvif_req_pvld) begin
      req_pd <= csb2cvif_req_pd;
    end
  end

  // field split
  assign req_addr    = req_pd[REQ_ADDR_MSB:REQ_ADDR_LSB];
  assign req_wdat    = req_pd[REQ_WDAT_MSB:REQ_WDAT_LSB];
  assign req_write   = req_pd[REQ_WRITE_BIT];
  assign req_nposted = req_pd[REQ_NPOSTED_BIT];

  // ==================================================
  // register access
  // ==================================================
  assign reg_offset  = {req_addr[9:0], 2'b00};  // word to byte offset
  assign reg_wr_en   = req_vld & req_write;
  assign reg_wr_data = req_wdat;

  // ==================================================
  // response
  // ==================================================
  assign rsp_rd_vld = req_vld & ~req_write;
  assign rsp_wr_vld = req_vld & req_write & req_nposted;  // posted writes are silent
  assign rsp_vld    = rsp_rd_vld | rsp_wr_vld;

  assign rsp_kind = rsp_wr_vld ? RESP_WRITE : RESP_READ;
  assign rsp_data = rsp_rd_vld ? reg_rd_data : '0;  // write ack carries no data

  always_comb begin
    rsp_pd                               = '0;
    rsp_pd[RESP_KIND_BIT]                = rsp_kind;
    rsp_pd[RESP_ERR_BIT]                 = 1'b0;  // no error reporting
    rsp_pd[RESP_DATA_W-1:0]              = rsp_data;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cvif2csb_resp_valid <= 1'b0;
    end else begin
      cvif2csb_resp_valid <= rsp_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      cvif2csb_resp_pd <= rsp_pd;
    end
  end

endmodule

/* cvif/cvif_csb_reg.sv */
// CVIF configuration register file. Written and read by the CSB slave,
// exports arbitration weights and outstanding limits to the datapath.
`timescale 1ns/1ps

module cvif_csb_reg #(
  parameter int unsigned NUM_CLIENTS = 4
) (
  input  logic                                    nvdla_core_clk,
  input  logic                                    nvdla_core_rstn,
  input  logic [11:0]                             reg_offset,
  input  logic                                    reg_wr_en,
  input  logic [31:0]                             reg_wr_data,
  output logic [31:0]                             reg_rd_data,
  input  logic                                    dp2reg_idle,
  output logic [NUM_CLIENTS*cvif_pkg::WEIGHT_W-1:0] reg2dp_rd_weight,
  output logic [NUM_CLIENTS*cvif_pkg::WEIGHT_W-1:0] reg2dp_wr_weight,
  output logic [cvif_pkg::WEIGHT_W-1:0]           reg2dp_rd_os_cnt,
  output logic [cvif_pkg::WEIGHT_W-1:0]           reg2dp_wr_os_cnt
);
  import cvif_pkg::*;

  localparam int unsigned WT_BUS_W = NUM_CLIENTS * WEIGHT_W;

  cvif_reg_e   reg_sel;
  logic        wr_rd_weight;
  logic        wr_wr_weight;
  logic        wr_os_cnt;
  logic [31:0] rd_weight_word;
  logic [31:0] wr_weight_word;
  logic [31:0] os_cnt_word;
  logic [31:0] status_word;

  assign reg_sel = cvif_reg_e'(reg_offset);

  // ==================================================
  // write decode
  // ==================================================
  always_comb begin
    wr_rd_weight = 1'b0;
    wr_wr_weight = 1'b0;
    wr_os_cnt    = 1'b0;
    if (reg_wr_en) begin
      case (reg_sel)
        REG_RD_WEIGHT: wr_rd_weight = 1'b1;
        REG_WR_WEIGHT: wr_wr_weight = 1'b1;
        REG_OS_CNT:    wr_os_cnt    = 1'b1;
        default: ;  // status and holes ignore writes
      endcase
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reg2dp_rd_weight <= {NUM_CLIENTS{RST_WEIGHT}};
    end else if (wr_rd_weight) begin
      reg2dp_rd_weight <= reg_wr_data[WT_BUS_W-1:0];  // one byte per client
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reg2dp_wr_weight <= {NUM_CLIENTS{RST_WEIGHT}};
    end else if (wr_wr_weight) begin
      reg2dp_wr_weight <= reg_wr_data[WT_BUS_W-1:0];
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      reg2dp_rd_os_cnt <= RST_OS_CNT;
      reg2dp_wr_os_cnt <= RST_OS_CNT;
    end else if (wr_os_cnt) begin
      reg2dp_rd_os_cnt <= reg_wr_data[WEIGHT_W-1:0];
      reg2dp_wr_os_cnt <= reg_wr_data[2*WEIGHT_W-1:WEIGHT_W];
    end
  end

  // ==================================================
  // read mux
  // ==================================================
  // bytes past the last client read back as zero
  assign rd_weight_word = 32'(reg2dp_rd_weight);
  assign wr_weight_word = 32'(reg2dp_wr_weight);
  assign os_cnt_word    = {16'h0, reg2dp_wr_os_cnt, reg2dp_rd_os_cnt};
  assign status_word    = {31'h0, dp2reg_idle};

  always_comb begin
    case (reg_sel)
      REG_RD_WEIGHT: reg_rd_data = rd_weight_word;
      REG_WR_WEIGHT: reg_rd_data = wr_weight_word;
      REG_OS_CNT:    reg_rd_data = os_cnt_word;
      REG_STATUS:    reg_rd_data = status_word;
      default:       reg_rd_data = 32'h0;  // unmapped
    endcase
  end

endmodule

/* cvif/cvif_rd_arb.sv */
// Weighted round-robin read arbiter. Merges the client read request streams
// onto one memory read port, capped by the read outstanding limit.
`timescale 1ns/1ps

module cvif_rd_arb #(
  parameter int unsigned NUM_CLIENTS = 4,
  parameter int unsigned ADDR_W      = 32
) (
  input  logic                                    nvdla_core_clk,
  input  logic                                    nvdla_core_rstn,
  input  logic [NUM_CLIENTS*cvif_pkg::WEIGHT_W-1:0] reg2dp_rd_weight,
  input  logic [cvif_pkg::WEIGHT_W-1:0]           reg2dp_rd_os_cnt,
  input  logic [NUM_CLIENTS-1:0]                  client_rd_req_valid,
  input  logic [NUM_CLIENTS*ADDR_W-1:0]           client_rd_req_addr,
  output logic [NUM_CLIENTS-1:0]                  client_rd_req_ready,
  output logic                                    mem_rd_req_valid,
  input  logic                                    mem_rd_req_ready,
  output logic [ADDR_W-1:0]                       mem_rd_req_addr,
  output logic [1:0]                              mem_rd_req_src,
  input  logic                                    mem_rd_rsp_valid
);
  import cvif_pkg::*;

  logic [WEIGHT_W-1:0] weight [NUM_CLIENTS];
  logic [1:0]          cur_ptr;     // client holding the grant
  logic [WEIGHT_W-1:0] credit;      // consecutive transfers of cur_ptr
  logic [WEIGHT_W-1:0] os_cnt;      // reads in flight
  logic                keep;
  logic                found;
  logic [1:0]          nxt_idx;
  logic [1:0]          gnt_idx;
  logic                os_full;
  logic                mem_xfer;

  always_comb begin
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      weight[i] = reg2dp_rd_weight[i*WEIGHT_W +: WEIGHT_W];
    end
  end

  // ==================================================
  // grant selection
  // ==================================================
  assign keep = client_rd_req_valid[cur_ptr] && (weight[cur_ptr] != '0) &&
                (credit < weight[cur_ptr]);

  // walk from farthest to nearest so the nearest requester wins,
  // cur_ptr itself comes last in circular order
  always_comb begin
    logic [1:0] cand;
    found   = 1'b0;
    nxt_idx = cur_ptr;
    for (int k = NUM_CLIENTS; k >= 1; k--) begin
      cand = 2'((int'(cur_ptr) + k) % NUM_CLIENTS);
      if (client_rd_req_valid[cand] && (weight[cand] != '0)) begin
        found   = 1'b1;
        nxt_idx = cand;
      end
    end
  end

  assign gnt_idx = keep ? cur_ptr : nxt_idx;
  assign os_full = (os_cnt >= reg2dp_rd_os_cnt);  // limit 0 blocks all reads

  assign mem_rd_req_valid = (keep | found) & ~os_full;
  assign mem_rd_req_src   = gnt_idx;
  assign mem_rd_req_addr  = client_rd_req_addr[gnt_idx*ADDR_W +: ADDR_W];
  assign mem_xfer         = mem_rd_req_valid & mem_rd_req_ready;

  always_comb begin
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      client_rd_req_ready[i] = mem_rd_req_valid && mem_rd_req_ready &&
                               (gnt_idx == 2'(i));
    end
  end

  // ==================================================
  // pointer, credit and outstanding count
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cur_ptr <= 2'd0;
      credit  <= '0;
    end else if (mem_xfer) begin
      cur_ptr <= gnt_idx;
      credit  <= keep ? credit + 1'b1 : WEIGHT_W'(1);  // new owner restarts
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      os_cnt <= '0;
    end else begin
      case ({mem_xfer, mem_rd_rsp_valid})
        2'b10: if (os_cnt != '1) os_cnt <= os_cnt + 1'b1;  // saturate high
        2'b01: if (os_cnt != '0) os_cnt <= os_cnt - 1'b1;
        default: ;  // issue and return cancel out
      endcase
    end
  end

endmodule

/* src/cvif_top.sv */
// Top of the CVIF configuration and read arbitration subsystem.
// Ties the CSB slave, its register file and the read arbiter together.
`timescale 1ns/1ps

module cvif_top #(
  parameter int unsigned NUM_CLIENTS = 4,
  parameter int unsigned ADDR_W      = 32
) (
  input  logic                                    nvdla_core_clk,
  input  logic                                    nvdla_core_rstn,
  input  logic                                    csb2cvif_req_pvld,
  output logic                                    csb2cvif_req_prdy,
  input  logic [cvif_pkg::CSB_REQ_W-1:0]          csb2cvif_req_pd,
  output logic                                    cvif2csb_resp_valid,
  output logic [cvif_pkg::CSB_RESP_W-1:0]         cvif2csb_resp_pd,
  input  logic                                    dp2reg_idle,
  output logic [NUM_CLIENTS*cvif_pkg::WEIGHT_W-1:0] reg2dp_wr_weight,
  output logic [cvif_pkg::WEIGHT_W-1:0]           reg2dp_wr_os_cnt,
  input  logic [NUM_CLIENTS-1:0]                  client_rd_req_valid,
  input  logic [NUM_CLIENTS*ADDR_W-1:0]           client_rd_req_addr,
  output logic [NUM_CLIENTS-1:0]                  client_rd_req_ready,
  output logic                                    mem_rd_req_valid,
  input  logic                                    mem_rd_req_ready,
  output logic [ADDR_W-1:0]                       mem_rd_req_addr,
  output logic [1:0]                              mem_rd_req_src,
  input  logic                                    mem_rd_rsp_valid
);
  import cvif_pkg::*;

  logic [11:0]                     reg_offset;
  logic                            reg_wr_en;
  logic [31:0]                     reg_wr_data;
  logic [31:0]                     reg_rd_data;
  logic [NUM_CLIENTS*WEIGHT_W-1:0] reg2dp_rd_weight;
  logic [WEIGHT_W-1:0]             reg2dp_rd_os_cnt;

  cvif_csb u_csb (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .csb2cvif_req_pvld   (csb2cvif_req_pvld),
    .csb2cvif_req_prdy   (csb2cvif_req_prdy),
    .csb2cvif_req_pd     (csb2cvif_req_pd),
    .cvif2csb_resp_valid (cvif2csb_resp_valid),
    .cvif2csb_resp_pd    (cvif2csb_resp_pd),
    .reg_offset          (reg_offset),
    .reg_wr_en           (reg_wr_en),
    .reg_wr_data         (reg_wr_data),
    .reg_rd_data         (reg_rd_data)
  );

  cvif_csb_reg #(.NUM_CLIENTS(NUM_CLIENTS)) u_reg (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .reg_offset       (reg_offset),
    .reg_wr_en        (reg_wr_en),
    .reg_wr_data      (reg_wr_data),
    .reg_rd_data      (reg_rd_data),
    .dp2reg_idle      (dp2reg_idle),
    .reg2dp_rd_weight (reg2dp_rd_weight),
    .reg2dp_wr_weight (reg2dp_wr_weight),
    .reg2dp_rd_os_cnt (reg2dp_rd_os_cnt),
    .reg2dp_wr_os_cnt (reg2dp_wr_os_cnt)
  );

  cvif_rd_arb #(.NUM_CLIENTS(NUM_CLIENTS), .ADDR_W(ADDR_W)) u_rd_arb (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .reg2dp_rd_weight    (reg2dp_rd_weight),
    .reg2dp_rd_os_cnt    (reg2dp_rd_os_cnt),
    .client_rd_req_valid (client_rd_req_valid),
    .client_rd_req_addr  (client_rd_req_addr),
    .client_rd_req_ready (client_rd_req_ready),
    .mem_rd_req_valid    (mem_rd_req_valid),
    .mem_rd_req_ready    (mem_rd_req_ready),
    .mem_rd_req_addr     (mem_rd_req_addr),
    .mem_rd_req_src      (mem_rd_req_src),
    .mem_rd_rsp_valid    (mem_rd_rsp_valid)
  );

endmodule

/* sim/cvif_ref_model.svh */
// Reference model for the CVIF testbench. Included inside the testbench module.
// Keeps a register shadow and the weighted round-robin grant state.
`ifndef CVIF_REF_MODEL_SVH
`define CVIF_REF_MODEL_SVH

logic [31:0] sh_rd_wt;   // read weights with client 0 in the low byte
logic [31:0] sh_wr_wt;
logic [7:0]  sh_rd_os;   // read outstanding limit
logic [7:0]  sh_wr_os;
logic [1:0]  m_ptr;      // client that owns the grant
logic [7:0]  m_credit;   // transfers in a row by m_ptr
logic [7:0]  m_os;       // reads in flight

task automatic reset_model();
  sh_rd_wt = {4{RST_WEIGHT}};
  sh_wr_wt = {4{RST_WEIGHT}};
  sh_rd_os = RST_OS_CNT;
  sh_wr_os = RST_OS_CNT;
  m_ptr    = 2'd0;
  m_credit = 8'h0;
  m_os     = 8'h0;
endtask

function automatic logic [31:0] read_shadow(input logic [11:0] off, input logic idle);
  case (off)
    REG_RD_WEIGHT: return sh_rd_wt;
    REG_WR_WEIGHT: return sh_wr_wt;
    REG_OS_CNT:    return {16'h0, sh_wr_os, sh_rd_os};
    REG_STATUS:    return {31'h0, idle};
    default:       return 32'h0;  // hole in the map
  endcase
endfunction

task automatic write_shadow(input logic [11:0] off, input logic [31:0] data);
  case (off)
    REG_RD_WEIGHT: sh_rd_wt = data;
    REG_WR_WEIGHT: sh_wr_wt = data;
    REG_OS_CNT: begin
      sh_rd_os = data[7:0];
      sh_wr_os = data[15:8];
    end
    default: ;  // status is read only
  endcase
endtask

// idx gets this cycle's winner and kept says whether the owner stays
function automatic logic predict_grant(input logic [3:0] cv, input logic [31:0] wt,
                                       input logic [7:0] limit, output logic [1:0] idx,
                                       output logic kept);
  logic [1:0] c;
  logic       hit;
  idx  = m_ptr;
  kept = 1'b0;
  hit  = 1'b0;
  if (m_os >= limit) return 1'b0;
  if (cv[m_ptr] && (m_credit < wt[m_ptr*8 +: 8])) begin
    kept = 1'b1;
    return 1'b1;
  end
  for (int k = 1; k <= 4; k++) begin
    c = m_ptr + 2'(k);  // circular scan with the owner last
    if (!hit && cv[c] && (wt[c*8 +: 8] != 8'h0)) begin
      hit = 1'b1;
      idx = c;
    end
  end
  return hit;
endfunction

task automatic step_arbiter(input logic xfer, input logic [1:0] idx, input logic kept,
                            input logic rsp);
  if (xfer) begin
    if (kept) begin
      m_credit = m_credit + 8'd1;
    end else begin
      m_ptr    = idx;
      m_credit = 8'd1;  // new owner
    end
  end
  if (xfer && !rsp && (m_os != 8'hff)) begin
    m_os = m_os + 8'd1;
  end else if (!xfer && rsp && (m_os != 8'h0)) begin
    m_os = m_os - 8'd1;
  end
endtask

`endif

/* sim/tb_cvif.sv */
// Testbench for the CVIF subsystem. Drives CSB traffic, client reads and the
// memory port of cvif_top and checks every cycle against the reference model.
`timescale 1ns/1ps

module tb_cvif;
  import cvif_pkg::*;

  localparam int unsigned RUN_CYCLES = 20 + 610 + 470 + 60;  // sum over the tests

  logic         nvdla_core_clk;
  logic         nvdla_core_rstn;
  logic         csb2cvif_req_pvld;
  logic         csb2cvif_req_prdy;
  logic [62:0]  csb2cvif_req_pd;
  logic         cvif2csb_resp_valid;
  logic [33:0]  cvif2csb_resp_pd;
  logic         dp2reg_idle;
  logic [31:0]  reg2dp_wr_weight;
  logic [7:0]   reg2dp_wr_os_cnt;
  logic [3:0]   client_rd_req_valid;
  logic [127:0] client_rd_req_addr;
  logic [3:0]   client_rd_req_ready;
  logic         mem_rd_req_valid;
  logic         mem_rd_req_ready;
  logic [31:0]  mem_rd_req_addr;
  logic [1:0]   mem_rd_req_src;
  logic         mem_rd_rsp_valid;

  int unsigned  errors;
  int unsigned  checks;
  int unsigned  tests;
  int unsigned  xfers;      // memory transfers seen on the DUT
  logic         idle_next;  // dp2reg_idle for the next cycles
  logic         rv_q0;      // response pipeline two cycles deep
  logic         rv_q1;
  logic [33:0]  rsp_q0;
  logic [33:0]  rsp_q1;
  logic [31:0]  lag_rd_wt;  // shadow as the DUT outputs show it
  logic [31:0]  lag_wr_wt;
  logic [7:0]   lag_rd_os;
  logic [7:0]   lag_wr_os;

  `include "cvif_ref_model.svh"

  cvif_top #(.NUM_CLIENTS(4), .ADDR_W(32)) DUT (.*);

  always #50 nvdla_core_clk = ~nvdla_core_clk;

  // ==================================================
  // helpers
  // ==================================================
  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [62:0] csb_pkt(input logic [21:0] addr, input logic [31:0] data,
                                          input logic wr, input logic np);
    return {7'($urandom), np, wr, data, addr};  // top bits are don't care
  endfunction

  // drives 10 ns after the rising edge and checks at the falling edge
  task automatic run_cycle(input logic rv, input logic [62:0] pd, input logic [3:0] cv,
                           input logic mrdy, input logic mrsp);
    logic        exp_v;
    logic [33:0] exp_pd;
    logic [11:0] off;
    logic [31:0] s_rd_wt;
    logic [31:0] s_wr_wt;
    logic [7:0]  s_rd_os;
    logic [7:0]  s_wr_os;
    logic        g_v;
    logic [1:0]  g_idx;
    logic        g_kept;
    @(posedge nvdla_core_clk);
    #10;
    csb2cvif_req_pvld   = rv;
    csb2cvif_req_pd     = pd;
    client_rd_req_valid = cv;
    for (int i = 0; i < 4; i++) begin
      client_rd_req_addr[i*32 +: 32] = $urandom;
    end
    mem_rd_req_ready = mrdy;
    mem_rd_rsp_valid = mrsp;
    dp2reg_idle      = idle_next;
    s_rd_wt = sh_rd_wt;
    s_wr_wt = sh_wr_wt;
    s_rd_os = sh_rd_os;
    s_wr_os = sh_wr_os;
    exp_v   = 1'b0;
    exp_pd  = '0;
    if (rv) begin
      off = 12'({pd[REQ_ADDR_MSB:REQ_ADDR_LSB], 2'b00});  // byte offset
      if (!pd[REQ_WRITE_BIT]) begin
        exp_v  = 1'b1;
        exp_pd = {RESP_READ, 1'b0, read_shadow(off, idle_next)};
      end else begin
        write_shadow(off, pd[REQ_WDAT_MSB:REQ_WDAT_LSB]);
        if (pd[REQ_NPOSTED_BIT]) begin
          exp_v  = 1'b1;
          exp_pd = {RESP_WRITE, 1'b0, 32'h0};
        end
      end
    end
    @(negedge nvdla_core_clk);
    check_eq(64'(csb2cvif_req_prdy), 64'(1'b1), "request ready");
    check_eq(64'(cvif2csb_resp_valid), 64'(rv_q1), "response valid");
    if (rv_q1) check_eq(64'(cvif2csb_resp_pd), 64'(rsp_q1), "response packet");
    rv_q1  = rv_q0;
    rsp_q1 = rsp_q0;
    rv_q0  = exp_v;
    rsp_q0 = exp_pd;
    check_eq(64'(DUT.reg2dp_rd_weight), 64'(lag_rd_wt), "read weights");
    check_eq(64'(reg2dp_wr_weight), 64'(lag_wr_wt), "write weights");
    check_eq(64'(DUT.reg2dp_rd_os_cnt), 64'(lag_rd_os), "read limit");
    check_eq(64'(reg2dp_wr_os_cnt), 64'(lag_wr_os), "write limit");
    // arbiter against the model grant with the weights the DUT sees now
    g_v = predict_grant(cv, lag_rd_wt, lag_rd_os, g_idx, g_kept);
    check_eq(64'(mem_rd_req_valid), 64'(g_v), "mem request valid");
    check_eq(64'(client_rd_req_ready), 64'((g_v && mrdy) ? 4'b0001 << g_idx : 4'h0),
             "client ready");
    if (g_v) begin
      check_eq(64'(mem_rd_req_src), 64'(g_idx), "mem request source");
      check_eq(64'(mem_rd_req_addr), 64'(client_rd_req_addr[g_idx*32 +: 32]), "mem address");
    end
    if (mem_rd_req_valid && mem_rd_req_ready) xfers++;
    step_arbiter(g_v && mrdy, g_idx, g_kept, mrsp);
    lag_rd_wt = s_rd_wt;
    lag_wr_wt = s_wr_wt;
    lag_rd_os = s_rd_os;
    lag_wr_os = s_wr_os;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) run_cycle(1'b0, '0, 4'h0, 1'b0, 1'b0);
  endtask

  task automatic end_test(input string name, input int unsigned err_base);
    tests++;
    $display("%s: done, %0d errors", name, errors - err_base);
  endtask

  // ==================================================
  // watchdog
  // ==================================================
  initial begin
    #((RUN_CYCLES + 50) * 100);
    $display("simulation ran past its time limit and was stopped");
    $display("TEST FAILED");
    $finish;
  end

  // ==================================================
  // tests
  // ==================================================
  initial begin
    int unsigned e0;
    logic [31:0] wt;
    logic [7:0]  lim;
    nvdla_core_clk      = 1'b0;
    nvdla_core_rstn     = 1'b0;
    csb2cvif_req_pvld   = 1'b0;
    csb2cvif_req_pd     = '0;
    dp2reg_idle         = 1'b0;
    client_rd_req_valid = 4'h0;
    client_rd_req_addr  = '0;
    mem_rd_req_ready    = 1'b0;
    mem_rd_rsp_valid    = 1'b0;
    errors = 0;
    checks = 0;
    tests  = 0;
    xfers  = 0;
    rv_q0  = 1'b0;
    rv_q1  = 1'b0;
    rsp_q0 = '0;
    rsp_q1 = '0;
    void'($urandom(32'h659c));
    reset_model();
    lag_rd_wt = sh_rd_wt;
    lag_wr_wt = sh_wr_wt;
    lag_rd_os = sh_rd_os;
    lag_wr_os = sh_wr_os;
    idle_next = 1'($urandom);
    repeat (2) @(posedge nvdla_core_clk);
    #10 nvdla_core_rstn = 1'b1;

    // reset values of every register
    e0 = errors;
    for (int a = 0; a < 4; a++) begin
      run_cycle(1'b1, csb_pkt(22'(a), 32'h0, 1'b0, 1'b0), 4'h0, 1'b0, 1'b0);
      idle(2);
    end
    idle(2);
    end_test("reset values", e0);

    // random reads and writes, mapped and unmapped
    e0 = errors;
    idle_next = 1'($urandom);
    for (int n = 0; n < 200; n++) begin
      run_cycle(1'b1, csb_pkt(22'($urandom % 8), $urandom, 1'($urandom), 1'($urandom)),
                4'h0, 1'b0, 1'b0);
      idle($urandom % 3);  // back to back or with a gap
    end
    idle(3);
    end_test("random csb access", e0);

    // weighted round robin against the model
    e0 = errors;
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 4; i++) wt[i*8 +: 8] = 8'($urandom % 4);
      run_cycle(1'b1, csb_pkt(22'd0, wt, 1'b1, 1'b0), 4'h0, 1'b0, 1'b0);
      run_cycle(1'b1, csb_pkt(22'd2, {16'h0, 8'h10, 8'(4 + $urandom % 5)}, 1'b1, 1'b1),
                4'h0, 1'b0, 1'b0);
      idle(3);
      repeat (150) run_cycle(1'b0, '0, 4'($urandom), 1'($urandom), ($urandom % 3) == 0);
    end
    end_test("read arbitration", e0);

    // outstanding limit with responses held back
    e0 = errors;
    for (int k = 0; (k < 20) && (m_os != 8'h0); k++) begin
      run_cycle(1'b0, '0, 4'h0, 1'b0, 1'b1);  // drain reads in flight
    end
    for (int i = 0; i < 4; i++) wt[i*8 +: 8] = 8'(1 + $urandom % 3);
    lim = 8'(1 + $urandom % 6);
    run_cycle(1'b1, csb_pkt(22'd0, wt, 1'b1, 1'b0), 4'h0, 1'b0, 1'b0);
    run_cycle(1'b1, csb_pkt(22'd2, {16'h0, 8'h10, lim}, 1'b1, 1'b0), 4'h0, 1'b0, 1'b0);
    idle(3);
    xfers = 0;
    repeat (20) run_cycle(1'b0, '0, 4'hf, 1'b1, 1'b0);
    check_eq(64'(xfers), 64'(lim), "transfers up to the limit");
    check_eq(64'(mem_rd_req_valid), 64'(1'b0), "valid low at the limit");
    for (int r = 0; r < 3; r++) begin
      xfers = 0;
      run_cycle(1'b0, '0, 4'hf, 1'b1, 1'b1);  // one response back
      repeat (3) run_cycle(1'b0, '0, 4'hf, 1'b1, 1'b0);
      check_eq(64'(xfers), 64'(1), "one transfer per response");
    end
    end_test("outstanding limit", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
common/cvif_pkg.sv
cvif/cvif_csb.sv
cvif/cvif_csb_reg.sv
cvif/cvif_rd_arb.sv
src/cvif_top.sv
sim/tb_cvif.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the CVIF testbench with Verilator and runs it from the project root.
# The exit status is nonzero unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_cvif -f flist.f -o tb_cvif \
  && ./obj_dir/tb_cvif | tee /dev/stderr | grep -q "^TEST OK$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
